/* Bender.yml */
package:
  name: soc_bus_fabric

sources:
  - files:
      - source/soc_bus_pkg.sv
      - source/reset_debounce.sv
      - source/bus_decoder.sv
      - source/slave_access.sv
      - source/master_return.sv
      - source/soc_bus_fabric.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_soc_bus_fabric.sv

/* list.f */
+incdir+sim
source/soc_bus_pkg.sv
source/reset_debounce.sv
source/bus_decoder.sv
source/slave_access.sv
source/master_return.sv
source/soc_bus_fabric.sv
sim/tb_soc_bus_fabric.sv

/* sim/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: IO tag, byte address or port, we, sel, write data, expected slot, expected read data
// Read data of an addressed slave model is {slot, word address bits 11:0}
// An idle slave model drives only its slot number
typedef struct packed {
  logic                                 io;
  logic [19:0]                          addr;
  logic                                 we;
  logic [soc_bus_pkg::SEL_W-1:0]        sel;
  logic [soc_bus_pkg::DATA_W-1:0]       wdat;
  logic [soc_bus_pkg::SLOT_W-1:0]       slot;
  logic [soc_bus_pkg::DATA_W-1:0]       rdat;
} vec_row_t;

localparam int NUM_ROWS = 18;

vec_row_t vec_table[$];

task automatic add_row(input vec_row_t row);
  vec_table.push_back(row);
endtask

task automatic fill_table();
  // Memory space, ROM before RAM
  add_row({1'b0, 20'hFFFF0, 1'b0, 2'b11, 16'h0000, soc_bus_pkg::SLOT_ROM,   16'h0FF8});
  add_row({1'b0, 20'hFFF00, 1'b1, 2'b11, 16'h1234, soc_bus_pkg::SLOT_ROM,   16'h0000});
  add_row({1'b0, 20'hFFEFE, 1'b0, 2'b11, 16'h0000, soc_bus_pkg::SLOT_RAM,   16'h8F7F});
  add_row({1'b0, 20'h00100, 1'b0, 2'b01, 16'h0000, soc_bus_pkg::SLOT_RAM,   16'h8080});
  add_row({1'b0, 20'hA0010, 1'b0, 2'b11, 16'h0000, soc_bus_pkg::SLOT_VGA,   16'h1008});
  add_row({1'b0, 20'hBFFFE, 1'b1, 2'b10, 16'hBEEF, soc_bus_pkg::SLOT_VGA,   16'h0000});
  // IO ports
  add_row({1'b1, 20'h003C4, 1'b0, 2'b11, 16'h0000, soc_bus_pkg::SLOT_VGA,   16'h11E2});
  add_row({1'b1, 20'h003F8, 1'b0, 2'b01, 16'h0000, soc_bus_pkg::SLOT_UART,  16'h21FC});
  add_row({1'b1, 20'h003FE, 1'b1, 2'b11, 16'h5A5A, soc_bus_pkg::SLOT_UART,  16'h0000});
  // Keyboard and speaker share port 60h
  // Speaker read takes its low byte from the idle keyboard
  add_row({1'b1, 20'h00060, 1'b0, 2'b10, 16'h0000, soc_bus_pkg::SLOT_AUDIO, 16'h4000});
  add_row({1'b1, 20'h00060, 1'b0, 2'b01, 16'h0000, soc_bus_pkg::SLOT_KEYB,  16'h3030});
  add_row({1'b1, 20'h00064, 1'b0, 2'b11, 16'h0000, soc_bus_pkg::SLOT_KEYB,  16'h3032});
  add_row({1'b1, 20'h00062, 1'b0, 2'b10, 16'h0000, soc_bus_pkg::SLOT_KEYB,  16'h3031});
  add_row({1'b1, 20'h00040, 1'b0, 2'b11, 16'h0000, soc_bus_pkg::SLOT_TIMER, 16'h5020});
  add_row({1'b1, 20'h00100, 1'b0, 2'b11, 16'h0000, soc_bus_pkg::SLOT_SD,    16'h6080});
  add_row({1'b1, 20'h0F102, 1'b0, 2'b11, 16'h0000, soc_bus_pkg::SLOT_GPIO,  16'h7881});
  // Unmapped ports
  add_row({1'b1, 20'h00080, 1'b0, 2'b11, 16'h0000, soc_bus_pkg::SLOT_DEFAULT, 16'h0000});
  add_row({1'b1, 20'h01234, 1'b1, 2'b11, 16'hC0DE, soc_bus_pkg::SLOT_DEFAULT, 16'h0000});
endtask

`endif

/* sim/tb_soc_bus_fabric.sv */
`timescale 1ns/1ns

module tb_soc_bus_fabric;

  `include "tb_vectors.svh"

  // Two reset holds, then the table
  localparam int CYCLE_LIMIT = 2 * (soc_bus_pkg::RST_HOLD_CYCLES + 20) + 10 * NUM_ROWS;

  logic                                                   clk;
  logic                                                   rst_lck;
  logic                                                   soft_rst_i;
  logic                                                   sys_rst_o;
  logic                                                   m_cyc_i;
  logic                                                   m_stb_i;
  logic                                                   m_tga_i;
  logic [soc_bus_pkg::ADR_W-1:0]                          m_adr_i;
  logic                                                   m_we_i;
  logic [soc_bus_pkg::SEL_W-1:0]                          m_sel_i;
  logic [soc_bus_pkg::DATA_W-1:0]                         m_dat_i;
  logic                                                   inta_i;
  logic                                                   nmia_i;
  logic [soc_bus_pkg::IID_W-1:0]                          iid_i;
  logic                                                   m_ack_o;
  logic [soc_bus_pkg::DATA_W-1:0]                         m_dat_o;
  logic [soc_bus_pkg::ADR_W-1:0]                          s_adr_o;
  logic                                                   s_tga_o;
  logic                                                   s_we_o;
  logic [soc_bus_pkg::SEL_W-1:0]                          s_sel_o;
  logic [soc_bus_pkg::DATA_W-1:0]                         s_dat_o;
  logic                                                   s_stb_o;
  logic [soc_bus_pkg::NUM_SLAVES-1:0]                     s_cyc_o;
  logic [soc_bus_pkg::NUM_SLAVES-1:0]                     s_ack_i;
  logic [soc_bus_pkg::NUM_SLAVES-1:0][soc_bus_pkg::DATA_W-1:0] s_dat_i;

  int cycle_cnt;
  int ack_delay;
  int ack_wait;
  logic slave_busy;

  soc_bus_fabric u_dut (.*);

  initial clk = 1'b0;
  always #50 clk = !clk;

  ////////////////////
  // Slave models
  ////////////////////
  always_comb begin
    for (int i = 0; i < soc_bus_pkg::NUM_SLAVES; i++) begin
      if (s_cyc_o[i]) begin
        s_dat_i[i] = {i[3:0], s_adr_o[11:0]};   // Slot number and low address bits
      end else begin
        s_dat_i[i] = {i[3:0], 12'h000};
      end
    end
  end

  // Random 0 to 3 cycle ack delay, only the addressed slave answers
  always @(negedge clk) begin
    if (s_stb_o && (s_cyc_o != '0)) begin
      if (!slave_busy) begin
        slave_busy = 1'b1;
        ack_delay  = $urandom % 4;
        ack_wait   = 0;
      end
      s_ack_i  <= (ack_wait >= ack_delay) ? s_cyc_o : '0;
      ack_wait = ack_wait + 1;
    end else begin
      slave_busy = 1'b0;
      s_ack_i    <= '0;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      stop_on_error($sformatf("Run timed out after %0d cycles", cycle_cnt));
    end
  end

  ////////////////////
  // Compare tasks
  ////////////////////
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  task automatic check_slot(input string name,
                            input logic [soc_bus_pkg::NUM_SLAVES-1:0] exp,
                            input logic [soc_bus_pkg::NUM_SLAVES-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  task automatic check_data(input string name,
                            input logic [soc_bus_pkg::DATA_W-1:0] exp,
                            input logic [soc_bus_pkg::DATA_W-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_adr(input string name,
                           input logic [soc_bus_pkg::ADR_W-1:0] exp,
                           input logic [soc_bus_pkg::ADR_W-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_sel(input string name,
                           input logic [soc_bus_pkg::SEL_W-1:0] exp,
                           input logic [soc_bus_pkg::SEL_W-1:0] act);
    if (act !== exp) begin
      stop_on_error($sformatf("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  // Counts edges from release until sys_rst_o falls
  task automatic check_release();
    for (int k = 1; k <= soc_bus_pkg::RST_HOLD_CYCLES + 1; k++) begin
      @(negedge clk);
      check_bit("sys_rst_o", k <= soc_bus_pkg::RST_HOLD_CYCLES, sys_rst_o);
      check_slot("s_cyc_o", '0, s_cyc_o);
      check_bit("s_stb_o", 1'b0, s_stb_o);
      check_bit("m_ack_o", 1'b0, m_ack_o);
    end
  endtask

  ////////////////////
  // Transactions
  ////////////////////
  task automatic run_row(input vec_row_t row);
    soc_bus_pkg::bus_addr_u          a;
    logic [soc_bus_pkg::NUM_SLAVES-1:0] exp_cyc;
    logic                            saw_stb;
    if (row.io) begin
      a.io.tag  = 1'b1;
      a.io.pad  = 4'h0;
      a.io.port = row.addr[15:1];
    end else begin
      a.mem.tag  = 1'b0;
      a.mem.wadr = row.addr[19:1];
    end
    exp_cyc = '0;
    if (row.slot != soc_bus_pkg::SLOT_DEFAULT) begin
      exp_cyc[row.slot] = 1'b1;
    end
    saw_stb = 1'b0;
    m_cyc_i = 1'b1;
    m_stb_i = 1'b1;
    m_tga_i = a.mem.tag;
    m_adr_i = a.mem.wadr;
    m_we_i  = row.we;
    m_sel_i = row.sel;
    m_dat_i = row.wdat;
    @(negedge clk);
    while (!m_ack_o) begin
      if (s_stb_o) begin
        saw_stb = 1'b1;
        check_slot("s_cyc_o", exp_cyc, s_cyc_o);
        check_adr("s_adr_o", a.mem.wadr, s_adr_o);
        check_bit("s_tga_o", a.mem.tag, s_tga_o);
        check_bit("s_we_o", row.we, s_we_o);
        check_sel("s_sel_o", row.sel, s_sel_o);
        check_data("s_dat_o", row.wdat, s_dat_o);
      end
      @(negedge clk);
    end
    if (!saw_stb) begin
      stop_on_error($sformatf("No slave strobe seen for address %h", row.addr));
    end
    if (!row.we) begin
      check_data("m_dat_o", row.rdat, m_dat_o);
    end
    m_cyc_i = 1'b0;
    m_stb_i = 1'b0;
    @(negedge clk);
    check_bit("m_ack_o", 1'b0, m_ack_o);   // Single-cycle ack
  endtask

  initial begin
    cycle_cnt   = 0;
    slave_busy  = 1'b0;
    ack_delay   = 0;
    ack_wait    = 0;
    void'($urandom(32'hce0523e3));
    rst_lck    = 1'b0;
    soft_rst_i = 1'b0;
    m_cyc_i    = 1'b0;
    m_stb_i    = 1'b0;
    m_tga_i    = 1'b0;
    m_adr_i    = '0;
    m_we_i     = 1'b0;
    m_sel_i    = '0;
    m_dat_i    = '0;
    inta_i     = 1'b0;
    nmia_i     = 1'b0;
    iid_i      = '0;
    s_ack_i    = '0;
    fill_table();

    repeat (4) @(negedge clk);
    rst_lck = 1'b1;
    check_release();

    // Soft reset restarts the hold
    soft_rst_i = 1'b1;
    @(negedge clk);
    check_bit("sys_rst_o", 1'b1, sys_rst_o);
    soft_rst_i = 1'b0;
    // Master already requesting, held off by the reset
    m_cyc_i    = 1'b1;
    m_stb_i    = 1'b1;
    check_release();

    foreach (vec_table[r]) begin
      run_row(vec_table[r]);
    end

    // Vector override, NMI first
    nmia_i = 1'b1;
    #20;
    check_data("m_dat_o", soc_bus_pkg::NMI_VECTOR, m_dat_o);
    @(negedge clk);
    inta_i = 1'b1;
    iid_i  = 3'd5;
    #20;
    check_data("m_dat_o", soc_bus_pkg::NMI_VECTOR, m_dat_o);
    @(negedge clk);
    nmia_i = 1'b0;
    #20;
    check_data("m_dat_o", soc_bus_pkg::INT_VECTOR_BASE + 16'd5, m_dat_o);
    @(negedge clk);
    iid_i = 3'd7;
    #20;
    check_data("m_dat_o", soc_bus_pkg::INT_VECTOR_BASE + 16'd7, m_dat_o);
    @(negedge clk);
    inta_i = 1'b0;

    $display("Test passed");
    $finish;
  end

endmodule

/* source/bus_decoder.sv */
`timescale 1ns/1ns

module bus_decoder (
  input  logic                             clk,
  input  logic                             sys_rst_i,
  input  logic                             m_cyc_i,
  input  logic                             m_stb_i,
  input  logic                             m_tga_i,
  input  logic [soc_bus_pkg::ADR_W-1:0]    m_adr_i,
  input  logic                             m_we_i,
  input  logic [soc_bus_pkg::SEL_W-1:0]    m_sel_i,
  input  logic [soc_bus_pkg::DATA_W-1:0]   m_dat_i,
  input  logic                             m_ack_i,
  output logic                             req_valid_o,
  output logic [soc_bus_pkg::SLOT_W-1:0]   slot_o,
  output logic [soc_bus_pkg::ADR_W-1:0]    s_adr_o,
  output logic                             s_tga_o,
  output logic                             s_we_o,
  output logic [soc_bus_pkg::SEL_W-1:0]    s_sel_o,
  output logic [soc_bus_pkg::DATA_W-1:0]   s_dat_o
);

  soc_bus_pkg::bus_addr_u          req_addr;
  logic [soc_bus_pkg::SLOT_W-1:0]  dec_slot;
  logic                            req_take;

  function automatic logic win_hit(
    input soc_bus_pkg::bus_addr_u           a,
    input logic [soc_bus_pkg::WIN_W-1:0]    base,
    input logic [soc_bus_pkg::WIN_W-1:0]    mask
  );
    return (a & mask) == base;
  endfunction

  always_comb begin
    req_addr.mem.tag  = m_tga_i;
    req_addr.mem.wadr = m_adr_i;
  end

  ////////////////////
  // Window match, first hit wins
  ////////////////////
  always_comb begin
    if (win_hit(req_addr, soc_bus_pkg::ROM_ADDR, soc_bus_pkg::ROM_MASK)) begin
      dec_slot = soc_bus_pkg::SLOT_ROM;   // Must beat RAM
    end else if (win_hit(req_addr, soc_bus_pkg::VGA_MEM_ADDR, soc_bus_pkg::VGA_MEM_MASK) ||
                 win_hit(req_addr, soc_bus_pkg::VGA_IO_ADDR, soc_bus_pkg::VGA_IO_MASK)) begin
      dec_slot = soc_bus_pkg::SLOT_VGA;
    end else if (win_hit(req_addr, soc_bus_pkg::UART_ADDR, soc_bus_pkg::UART_MASK)) begin
      dec_slot = soc_bus_pkg::SLOT_UART;
    end else if (win_hit(req_addr, soc_bus_pkg::KEYB_ADDR, soc_bus_pkg::KEYB_MASK)) begin
      // Offset 0 high byte is port 61h, the speaker control
      if (req_addr.io.port[1:0] == 2'b00 && m_sel_i[1]) begin
        dec_slot = soc_bus_pkg::SLOT_AUDIO;
      end else begin
        dec_slot = soc_bus_pkg::SLOT_KEYB;
      end
    end else if (win_hit(req_addr, soc_bus_pkg::TIMER_ADDR, soc_bus_pkg::TIMER_MASK)) begin
      dec_slot = soc_bus_pkg::SLOT_TIMER;
    end else if (win_hit(req_addr, soc_bus_pkg::SD_ADDR, soc_bus_pkg::SD_MASK)) begin
      dec_slot = soc_bus_pkg::SLOT_SD;
    end else if (win_hit(req_addr, soc_bus_pkg::GPIO_ADDR, soc_bus_pkg::GPIO_MASK)) begin
      dec_slot = soc_bus_pkg::SLOT_GPIO;
    end else if (win_hit(req_addr, soc_bus_pkg::RAM_ADDR, soc_bus_pkg::RAM_MASK)) begin
      dec_slot = soc_bus_pkg::SLOT_RAM;
    end else begin
      dec_slot = soc_bus_pkg::SLOT_DEFAULT;  // Unmapped IO
    end
  end

  // Only idle, and not in the master's ack cycle
  assign req_take = m_cyc_i && m_stb_i && !m_ack_i && !req_valid_o;

  ////////////////////
  // Request stage
  ////////////////////
  always_ff @(posedge clk) begin
    if (sys_rst_i) begin
      req_valid_o <= 1'b0;
    end else if (req_take) begin
      req_valid_o <= 1'b1;
    end else if (m_ack_i) begin
      req_valid_o <= 1'b0;   // Done once the master has seen its ack
    end
  end

  always_ff @(posedge clk) begin
    if (req_take) begin
      slot_o  <= dec_slot;
      s_adr_o <= m_adr_i;
      s_tga_o <= m_tga_i;
      s_we_o  <= m_we_i;
      s_sel_o <= m_sel_i;
      s_dat_o <= m_dat_i;
    end
  end

endmodule

/* source/master_return.sv */
`timescale 1ns/1ns

module master_return (
  input  logic                            clk,
  input  logic                            sys_rst_i,
  input  logic                            hit_i,
  input  logic [soc_bus_pkg::DATA_W-1:0]  hit_dat_i,
  input  logic                            inta_i,
  input  logic                            nmia_i,
  input  logic [soc_bus_pkg::IID_W-1:0]   iid_i,
  output logic                            m_ack_o,
  output logic [soc_bus_pkg::DATA_W-1:0]  m_dat_o
);

  logic [soc_bus_pkg::DATA_W-1:0] dat_q;
  logic [soc_bus_pkg::DATA_W-1:0] int_vec;

  // hit_i is a single-cycle pulse, so is the ack
  always_ff @(posedge clk) begin
    if (sys_rst_i) begin
      m_ack_o <= 1'b0;
    end else begin
      m_ack_o <= hit_i;
    end
  end

  always_ff @(posedge clk) begin
    if (hit_i) begin
      dat_q <= hit_dat_i;   // Held until the next hit
    end
  end

  assign int_vec = soc_bus_pkg::INT_VECTOR_BASE +
                   {{(soc_bus_pkg::DATA_W - soc_bus_pkg::IID_W){1'b0}}, iid_i};

  ////////////////////
  // Vector override
  ////////////////////
  // NMI acknowledge takes precedence over INTA
  always_comb begin
    if (nmia_i) begin
      m_dat_o = soc_bus_pkg::NMI_VECTOR;
    end else if (inta_i) begin
      m_dat_o = int_vec;
    end else begin
      m_dat_o = dat_q;
    end
  end

endmodule

/* source/reset_debounce.sv */
`timescale 1ns/1ns

module reset_debounce (
  input  logic clk,
  input  logic rst_lck,
  input  logic soft_rst_i,
  output logic sys_rst_o
);

  logic [soc_bus_pkg::RST_CNT_W-1:0] hold_cnt;
  logic                              rst_req;

  // Board reset is active low, soft reset from the keyboard controller
  assign rst_req = !rst_lck || soft_rst_i;

  // Hold counter, reloads for as long as either source is active
  always_ff @(posedge clk) begin
    if (rst_req) begin
      hold_cnt <= soc_bus_pkg::RST_HOLD_CYCLES;
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  // Released on the edge that sees the counter at zero
  always_ff @(posedge clk) begin
    if (rst_req) begin
      sys_rst_o <= 1'b1;
    end else begin
      sys_rst_o <= hold_cnt != '0;
    end
  end

endmodule

/* source/slave_access.sv */
`timescale 1ns/1ns

module slave_access (
  input  logic                                                   clk,
  input  logic                                                   sys_rst_i,
  input  logic                                                   req_valid_i,
  input  logic [soc_bus_pkg::SLOT_W-1:0]                         slot_i,
  input  logic [soc_bus_pkg::NUM_SLAVES-1:0]                     s_ack_i,
  input  logic [soc_bus_pkg::NUM_SLAVES-1:0][soc_bus_pkg::DATA_W-1:0] s_dat_i,
  output logic [soc_bus_pkg::NUM_SLAVES-1:0]                     s_cyc_o,
  output logic                                                   s_stb_o,
  output logic                                                   hit_o,
  output logic [soc_bus_pkg::DATA_W-1:0]                         hit_dat_o
);

  logic                            acked;
  logic                            dflt_sel;
  logic                            slave_ack;
  logic [soc_bus_pkg::DATA_W-1:0]  sel_dat;
  logic [soc_bus_pkg::DATA_W-1:0]  keyb_dat;
  logic [soc_bus_pkg::DATA_W-1:0]  aud_dat;

  ////////////////////
  // Strobes
  ////////////////////
  // One-hot cycle line, held until the request stage lets go
  always_comb begin
    for (int i = 0; i < soc_bus_pkg::NUM_SLAVES; i++) begin
      s_cyc_o[i] = req_valid_i && (int'(slot_i) == i);
    end
  end

  assign s_stb_o   = req_valid_i && !acked;
  assign dflt_sel  = slot_i == soc_bus_pkg::SLOT_DEFAULT;
  assign slave_ack = |(s_ack_i & s_cyc_o);   // Only the addressed slave counts

  // Default slave answers in its first cycle
  assign hit_o = s_stb_o && (dflt_sel || slave_ack);

  // Keeps stb low between the ack and the end of the request
  always_ff @(posedge clk) begin
    if (sys_rst_i || !req_valid_i) begin
      acked <= 1'b0;
    end else if (hit_o) begin
      acked <= 1'b1;
    end
  end

  ////////////////////
  // Read data select
  ////////////////////
  always_comb begin
    sel_dat = '0;
    for (int i = 0; i < soc_bus_pkg::NUM_SLAVES; i++) begin
      if (int'(slot_i) == i) begin
        sel_dat = s_dat_i[i];
      end
    end
  end

  assign keyb_dat = s_dat_i[soc_bus_pkg::SLOT_KEYB];
  assign aud_dat  = s_dat_i[soc_bus_pkg::SLOT_AUDIO];

  // Keyboard port shares its low byte, high byte from whoever was addressed
  always_comb begin
    case (slot_i)
      soc_bus_pkg::SLOT_KEYB: begin
        hit_dat_o = {keyb_dat[15:8], keyb_dat[7:0]};
      end
      soc_bus_pkg::SLOT_AUDIO: begin
        hit_dat_o = {aud_dat[15:8], keyb_dat[7:0]};
      end
      soc_bus_pkg::SLOT_DEFAULT: begin
        hit_dat_o = '0;
      end
      default: begin
        hit_dat_o = sel_dat;
      end
    endcase
  end

endmodule

/* source/soc_bus_fabric.sv */
`timescale 1ns/1ns

module soc_bus_fabric (
  input  logic                                                   clk,
  input  logic                                                   rst_lck,
  input  logic                                                   soft_rst_i,
  output logic                                                   sys_rst_o,

  // Master side
  input  logic                                                   m_cyc_i,
  input  logic                                                   m_stb_i,
  input  logic                                                   m_tga_i,
  input  logic [soc_bus_pkg::ADR_W-1:0]                          m_adr_i,
  input  logic                                                   m_we_i,
  input  logic [soc_bus_pkg::SEL_W-1:0]                          m_sel_i,
  input  logic [soc_bus_pkg::DATA_W-1:0]                         m_dat_i,
  input  logic                                                   inta_i,
  input  logic                                                   nmia_i,
  input  logic [soc_bus_pkg::IID_W-1:0]                          iid_i,
  output logic                                                   m_ack_o,
  output logic [soc_bus_pkg::DATA_W-1:0]                         m_dat_o,

  // Slave side
  output logic [soc_bus_pkg::ADR_W-1:0]                          s_adr_o,
  output logic                                                   s_tga_o,
  output logic                                                   s_we_o,
  output logic [soc_bus_pkg::SEL_W-1:0]                          s_sel_o,
  output logic [soc_bus_pkg::DATA_W-1:0]                         s_dat_o,
  output logic                                                   s_stb_o,
  output logic [soc_bus_pkg::NUM_SLAVES-1:0]                     s_cyc_o,
  input  logic [soc_bus_pkg::NUM_SLAVES-1:0]                     s_ack_i,
  input  logic [soc_bus_pkg::NUM_SLAVES-1:0][soc_bus_pkg::DATA_W-1:0] s_dat_i
);

  logic                            req_valid;
  logic [soc_bus_pkg::SLOT_W-1:0]  slot;
  logic                            hit;
  logic [soc_bus_pkg::DATA_W-1:0]  hit_dat;

  reset_debounce u_reset_debounce (
    .clk        (clk),
    .rst_lck    (rst_lck),
    .soft_rst_i (soft_rst_i),
    .sys_rst_o  (sys_rst_o)
  );

  // Request stage
  bus_decoder u_bus_decoder (
    .clk         (clk),
    .sys_rst_i   (sys_rst_o),
    .m_cyc_i     (m_cyc_i),
    .m_stb_i     (m_stb_i),
    .m_tga_i     (m_tga_i),
    .m_adr_i     (m_adr_i),
    .m_we_i      (m_we_i),
    .m_sel_i     (m_sel_i),
    .m_dat_i     (m_dat_i),
    .m_ack_i     (m_ack_o),     // Ends the request
    .req_valid_o (req_valid),
    .slot_o      (slot),
    .s_adr_o     (s_adr_o),
    .s_tga_o     (s_tga_o),
    .s_we_o      (s_we_o),
    .s_sel_o     (s_sel_o),
    .s_dat_o     (s_dat_o)
  );

  // Slave access stage
  slave_access u_slave_access (
    .clk         (clk),
    .sys_rst_i   (sys_rst_o),
    .req_valid_i (req_valid),
    .slot_i      (slot),
    .s_ack_i     (s_ack_i),
    .s_dat_i     (s_dat_i),
    .s_cyc_o     (s_cyc_o),
    .s_stb_o     (s_stb_o),
    .hit_o       (hit),
    .hit_dat_o   (hit_dat)
  );

  // Master return stage
  master_return u_master_return (
    .clk       (clk),
    .sys_rst_i (sys_rst_o),
    .hit_i     (hit),
    .hit_dat_i (hit_dat),
    .inta_i    (inta_i),
    .nmia_i    (nmia_i),
    .iid_i     (iid_i),
    .m_ack_o   (m_ack_o),
    .m_dat_o   (m_dat_o)
  );

endmodule

/* source/soc_bus_pkg.sv */
package soc_bus_pkg;

  ////////////////////
  // Bus widths
  ////////////////////
  localparam int DATA_W     = 16;
  localparam int ADR_W      = 19;         // Word address, byte address bits 19 to 1
  localparam int SEL_W      = 2;
  localparam int WIN_W      = ADR_W + 1;  // Tag plus word address
  localparam int NUM_SLAVES = 9;
  localparam int SLOT_W     = 4;
  localparam int IID_W      = 3;

  ////////////////////
  // Slot numbers
  ////////////////////
  // Decode priority follows the numbering
  localparam logic [SLOT_W-1:0] SLOT_ROM     = 4'd0;
  localparam logic [SLOT_W-1:0] SLOT_VGA     = 4'd1;
  localparam logic [SLOT_W-1:0] SLOT_UART    = 4'd2;
  localparam logic [SLOT_W-1:0] SLOT_KEYB    = 4'd3;
  localparam logic [SLOT_W-1:0] SLOT_AUDIO   = 4'd4;   // Speaker half of port 61h
  localparam logic [SLOT_W-1:0] SLOT_TIMER   = 4'd5;
  localparam logic [SLOT_W-1:0] SLOT_SD      = 4'd6;
  localparam logic [SLOT_W-1:0] SLOT_GPIO    = 4'd7;
  localparam logic [SLOT_W-1:0] SLOT_RAM     = 4'd8;
  localparam logic [SLOT_W-1:0] SLOT_DEFAULT = 4'd9;   // Internal, no cyc line

  ////////////////////
  // Decode windows
  ////////////////////
  // Word layout is {tag, adr[19:1]}, tag high for IO
  // IO windows ignore adr[19:16]
  localparam logic [WIN_W-1:0] ROM_ADDR     = 20'h7FF80;  // mem 0xFFF00 - 0xFFFFF
  localparam logic [WIN_W-1:0] ROM_MASK     = 20'hFFF80;
  localparam logic [WIN_W-1:0] VGA_MEM_ADDR = 20'h50000;  // mem 0xA0000 - 0xBFFFF
  localparam logic [WIN_W-1:0] VGA_MEM_MASK = 20'hF0000;
  localparam logic [WIN_W-1:0] VGA_IO_ADDR  = 20'h801E0;  // io 0x3C0 - 0x3DF
  localparam logic [WIN_W-1:0] VGA_IO_MASK  = 20'h87FF0;
  localparam logic [WIN_W-1:0] UART_ADDR    = 20'h801FC;  // io 0x3F8 - 0x3FF
  localparam logic [WIN_W-1:0] UART_MASK    = 20'h87FFC;
  localparam logic [WIN_W-1:0] KEYB_ADDR    = 20'h80030;  // io 0x60 - 0x67
  localparam logic [WIN_W-1:0] KEYB_MASK    = 20'h87FFC;
  localparam logic [WIN_W-1:0] TIMER_ADDR   = 20'h80020;  // io 0x40 - 0x43
  localparam logic [WIN_W-1:0] TIMER_MASK   = 20'h87FFE;
  localparam logic [WIN_W-1:0] SD_ADDR      = 20'h80080;  // io 0x100 - 0x101
  localparam logic [WIN_W-1:0] SD_MASK      = 20'h87FFF;
  localparam logic [WIN_W-1:0] GPIO_ADDR    = 20'h87880;  // io 0xF100 - 0xF103
  localparam logic [WIN_W-1:0] GPIO_MASK    = 20'h87FFE;
  localparam logic [WIN_W-1:0] RAM_ADDR     = 20'h00000;  // Whole memory space
  localparam logic [WIN_W-1:0] RAM_MASK     = 20'h80000;

  ////////////////////
  // Reset hold
  ////////////////////
  localparam int                   RST_CNT_W       = 8;
  localparam logic [RST_CNT_W-1:0] RST_HOLD_CYCLES = 8'd255;

  ////////////////////
  // Acknowledge vectors
  ////////////////////
  localparam logic [DATA_W-1:0] NMI_VECTOR      = 16'h0002;
  localparam logic [DATA_W-1:0] INT_VECTOR_BASE = 16'h0008;  // iid goes in bits 2:0

  // One request word, seen as memory or as IO port
  typedef union packed {
    struct packed {
      logic             tag;
      logic [ADR_W-1:0] wadr;
    } mem;
    struct packed {
      logic        tag;
      logic [3:0]  pad;    // adr[19:16], not decoded for IO
      logic [14:0] port;   // Port bits 15 to 1
    } io;
  } bus_addr_u;

endpackage
